// File: imuldiv.f
+incdir+tests
common/imuldiv_pkg.sv
int_div/int_div_dpath.sv
int_div/int_div_ctrl.sv
int_div/int_div_iterative.sv
hdl/int_mul_iterative.sv
hdl/imuldiv_top.sv
tests/imuldiv_tb.sv

// File: Makefile
# Verilator build and run of the imuldiv testbench

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
FILELIST  ?= imuldiv.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the outcome, the simulator status alone does not
run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/imuldiv_ref.svh
// --------------------
// reference model of the multiply/divide unit
// --------------------
`ifndef IMULDIV_REF_SVH
`define IMULDIV_REF_SVH

// full signed product, or {remainder, quotient}
function automatic logic [63:0] imuldiv_ref(input imuldiv_pkg::muldiv_op_e op,
                                            input logic [31:0] a,
                                            input logic [31:0] b);
  longint sa;
  longint sb;
  longint mag_a;
  longint mag_b;
  longint quo;
  longint rem;
  logic   neg_a;
  logic   neg_b;
  sa = longint'($signed(a));
  sb = longint'($signed(b));
  if (op == imuldiv_pkg::OP_MUL) begin
    return sa * sb;
  end
  // signs only matter for the signed divide
  neg_a = (op == imuldiv_pkg::OP_DIV) && (sa < 0);
  neg_b = (op == imuldiv_pkg::OP_DIV) && (sb < 0);
  mag_a = neg_a ? -sa : longint'({32'd0, a});
  mag_b = neg_b ? -sb : longint'({32'd0, b});
  if (mag_b == 0) begin
    // zero divisor: all-ones quotient, dividend left over
    quo = 64'h0000_0000_ffff_ffff;
    rem = mag_a;
  end else begin
    quo = mag_a / mag_b;
    rem = mag_a % mag_b;
  end
  // quotient sign from both operands, remainder follows the dividend
  if (neg_a != neg_b) quo = -quo;
  if (neg_a) rem = -rem;
  return {rem[31:0], quo[31:0]};
endfunction

`endif

// File: tests/imuldiv_tb.sv
`timescale 1ns/1ps
// --------------------
// testbench for the multiply/divide unit
// directed and random ops against a reference model
// with back-pressure and latency checks
// --------------------
module imuldiv_tb;

  // --------------------
  // run lengths
  // --------------------
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = 33;
  localparam int MAX_STALL    = 8;
  localparam int N_DIVU       = 40;
  localparam int N_SDIV_DIR   = 12;
  localparam int N_SDIV_RAND  = 20;
  localparam int N_DIV_ZERO   = 6;
  localparam int N_MUL_EXT    = 8;
  localparam int N_MIX        = 30;
  localparam int N_STALL      = 30;
  localparam int N_OPS = N_DIVU + N_SDIV_DIR + N_SDIV_RAND + N_DIV_ZERO
                       + N_MUL_EXT + 2 * N_MIX + N_STALL;
  // each op takes the latency, its stall and a few handshake cycles
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_OPS * (LATENCY + MAX_STALL + 4);
  localparam logic [31:0] SEED = 32'h5259_7410;

  logic                    clk;
  logic                    reset;
  imuldiv_pkg::muldiv_op_e req_op;
  logic [31:0]             req_a;
  logic [31:0]             req_b;
  logic                    req_val;
  logic                    req_rdy;
  logic [63:0]             resp_result;
  logic                    resp_val;
  logic                    resp_rdy;

  int          seed;
  int          stall_seed;
  int          cycle = 0;
  int          accept_cycle = 0;
  int          issued = 0;
  int          done = 0;
  int          errors = 0;
  logic        stall_mode;
  // expected results in request order with one entry per op in flight
  logic [63:0] expect_q [$];

  `include "imuldiv_ref.svh"

  imuldiv_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // number of rising edges seen so far
  always @(posedge clk) cycle <= cycle + 1;

  // --------------------
  // helpers
  // --------------------

  task automatic report_failure(input string line);
    errors++;
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // random width and sign with zero now and then
  function automatic logic [31:0] rand_divisor();
    logic [31:0] v;
    logic [31:0] r;
    v = $random(seed);
    r = $random(seed);
    v = v >> r[4:0];
    if (r[5]) v = 32'd0 - v;
    return v;
  endfunction

  // called on a falling edge and holds the payload until the DUT is free
  task automatic issue_request(input imuldiv_pkg::muldiv_op_e op,
                               input logic [31:0] a, input logic [31:0] b);
    req_op  = op;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    while (!req_rdy) @(negedge clk);
    accept_cycle = cycle + 1;
    expect_q.push_back(imuldiv_ref(op, a, b));
    issued++;
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic wait_idle();
    while (done != issued) @(negedge clk);
    @(negedge clk);
  endtask

  // --------------------
  // stimulus
  // --------------------

  initial begin : stimulus
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             r;
    imuldiv_pkg::muldiv_op_e op;
    seed       = SEED;
    stall_seed = SEED + 1;
    stall_mode = 1'b0;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_op     = imuldiv_pkg::OP_MUL;
    req_a      = '0;
    req_b      = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    assert (req_rdy && !resp_val)
      else report_failure("handshake outputs wrong right after reset");

    // random unsigned divide
    for (int i = 0; i < N_DIVU; i++) begin
      a = rand_word();
      b = rand_divisor();
      issue_request(imuldiv_pkg::OP_DIVU, a, b);
    end

    // signed divide over all sign combinations and edge values
    issue_request(imuldiv_pkg::OP_DIV, 32'd7, 32'd2);
    issue_request(imuldiv_pkg::OP_DIV, -32'd7, 32'd2);
    issue_request(imuldiv_pkg::OP_DIV, 32'd7, -32'd2);
    issue_request(imuldiv_pkg::OP_DIV, -32'd7, -32'd2);
    issue_request(imuldiv_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    issue_request(imuldiv_pkg::OP_DIV, 32'h8000_0000, 32'd1);
    issue_request(imuldiv_pkg::OP_DIV, -32'd5, 32'd1);
    issue_request(imuldiv_pkg::OP_DIV, 32'd123456, 32'd1);
    issue_request(imuldiv_pkg::OP_DIV, 32'hffff_ffff, 32'hffff_ffff);
    issue_request(imuldiv_pkg::OP_DIV, 32'd0, -32'd3);
    issue_request(imuldiv_pkg::OP_DIV, 32'h8000_0000, 32'h8000_0000);
    issue_request(imuldiv_pkg::OP_DIV, 32'h7fff_ffff, 32'hffff_ffff);
    for (int i = 0; i < N_SDIV_RAND; i++) begin
      a = rand_word();
      b = rand_divisor();
      issue_request(imuldiv_pkg::OP_DIV, a, b);
    end

    // zero divisors
    issue_request(imuldiv_pkg::OP_DIV, 32'd5, 32'd0);
    issue_request(imuldiv_pkg::OP_DIV, -32'd5, 32'd0);
    issue_request(imuldiv_pkg::OP_DIV, 32'd0, 32'd0);
    issue_request(imuldiv_pkg::OP_DIV, 32'h8000_0000, 32'd0);
    issue_request(imuldiv_pkg::OP_DIVU, 32'd5, 32'd0);
    issue_request(imuldiv_pkg::OP_DIVU, 32'hffff_ffff, 32'd0);

    // multiply with extreme operands
    issue_request(imuldiv_pkg::OP_MUL, 32'h8000_0000, 32'h8000_0000);
    issue_request(imuldiv_pkg::OP_MUL, 32'h8000_0000, 32'h7fff_ffff);
    issue_request(imuldiv_pkg::OP_MUL, 32'h8000_0000, 32'hffff_ffff);
    issue_request(imuldiv_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
    issue_request(imuldiv_pkg::OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
    issue_request(imuldiv_pkg::OP_MUL, 32'd0, 32'h8000_0000);
    issue_request(imuldiv_pkg::OP_MUL, 32'd1, 32'hffff_ffff);
    issue_request(imuldiv_pkg::OP_MUL, 32'hffff_ffff, 32'h7fff_ffff);

    // multiply and divide back to back
    for (int i = 0; i < N_MIX; i++) begin
      a = rand_word();
      b = rand_word();
      issue_request(imuldiv_pkg::OP_MUL, a, b);
      r  = rand_word();
      op = r[0] ? imuldiv_pkg::OP_DIV : imuldiv_pkg::OP_DIVU;
      a  = rand_word();
      b  = rand_divisor();
      issue_request(op, a, b);
    end

    // random ops under back-pressure
    wait_idle();
    stall_mode = 1'b1;
    for (int i = 0; i < N_STALL; i++) begin
      r = rand_word();
      case (r % 3)
        0:       op = imuldiv_pkg::OP_MUL;
        1:       op = imuldiv_pkg::OP_DIV;
        default: op = imuldiv_pkg::OP_DIVU;
      endcase
      a = rand_word();
      b = (op == imuldiv_pkg::OP_MUL) ? rand_word() : rand_divisor();
      issue_request(op, a, b);
    end

    wait_idle();
    repeat (2) @(negedge clk);
    assert (req_rdy && !resp_val)
      else report_failure("DUT not idle with no request pending at the end of the run");
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // --------------------
  // response side drives resp_rdy and checks result, hold and latency
  // --------------------

  initial begin : response_side
    logic [63:0] expected;
    logic [63:0] held;
    logic        holding;
    logic        prev_val;
    logic        after_xfer;
    int          stall_left;
    resp_rdy   = 1'b1;
    held       = '0;
    holding    = 1'b0;
    prev_val   = 1'b0;
    after_xfer = 1'b0;
    stall_left = 0;
    forever begin
      @(negedge clk);
      // unit back in idle one cycle after the transfer
      if (after_xfer) begin
        assert (req_rdy && !resp_val)
          else report_failure("DUT not idle again after a response transfer");
        after_xfer = 1'b0;
      end
      if (resp_val) begin
        assert (!req_rdy)
          else report_failure("req_rdy high while a response is pending");
        if (!prev_val) begin
          assert (expect_q.size() == 1)
            else report_failure("response does not match exactly one request");
          assert (cycle - accept_cycle == LATENCY)
            else report_failure($sformatf("FAILED at %0d ns: latency %0d cycles, expected %0d",
                                          $time, cycle - accept_cycle, LATENCY));
          stall_left = stall_mode ? int'($unsigned($random(stall_seed)) % (MAX_STALL + 1)) : 0;
          holding    = 1'b0;
        end
        if (holding) begin
          assert (resp_result == held)
            else report_failure($sformatf("FAILED at %0d ns: result moved from %h to %h",
                                          $time, held, resp_result));
        end
        if (stall_left > 0) begin
          resp_rdy = 1'b0;
          stall_left--;
          held     = resp_result;
          holding  = 1'b1;
          prev_val = 1'b1;
        end else begin
          // transfer on the next rising edge
          expected = expect_q.pop_front();
          assert (resp_result == expected)
            else report_failure($sformatf("FAILED at %0d ns: result %h, expected %h",
                                          $time, resp_result, expected));
          resp_rdy   = 1'b1;
          holding    = 1'b0;
          after_xfer = 1'b1;
          prev_val   = 1'b0;
          done++;
        end
      end else begin
        resp_rdy = 1'b1;
        prev_val = 1'b0;
      end
    end
  end

  // --------------------
  // watchdog
  // --------------------

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the DUT stopped answering before all operations were done");
    $display("SOME TESTS FAILED");
    $fatal(1, "run took too long");
  end

endmodule

// File: hdl/imuldiv_top.sv
`timescale 1ns/1ps
// --------------------
// multiply/divide unit top
// dispatches by opcode and returns the owning unit's response
// with one op in flight
// --------------------
module imuldiv_top (
  input  logic                              clk,
  input  logic                              reset,
  input  imuldiv_pkg::muldiv_op_e           req_op,
  input  logic [imuldiv_pkg::DATA_W-1:0]    req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]    req_b,
  input  logic                              req_val,
  output logic                              req_rdy,
  output logic [imuldiv_pkg::RESULT_W-1:0]  resp_result,
  output logic                              resp_val,
  input  logic                              resp_rdy
);

  logic                             busy;
  // high while the multiplier owns the op in flight
  logic                             unit_mul;
  logic                             sel_mul;
  logic                             req_go;
  logic                             resp_go;

  logic                             div_req_val;
  logic                             div_req_rdy;
  logic [imuldiv_pkg::RESULT_W-1:0] div_resp_result;
  logic                             div_resp_val;
  logic                             mul_req_val;
  logic                             mul_req_rdy;
  logic [imuldiv_pkg::RESULT_W-1:0] mul_resp_result;
  logic                             mul_resp_val;

  // --------------------
  // dispatch
  // --------------------

  assign sel_mul = (req_op == imuldiv_pkg::OP_MUL);
  // both units are idle whenever the top is not busy so no cycle is added
  assign req_rdy = !busy && (sel_mul ? mul_req_rdy : div_req_rdy);
  assign req_go  = req_val && req_rdy;

  assign mul_req_val = req_val && !busy && sel_mul;
  assign div_req_val = req_val && !busy && !sel_mul;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      unit_mul <= 1'b0;
    end else if (req_go) begin
      busy     <= 1'b1;
      unit_mul <= sel_mul;
    end else if (resp_go) begin
      busy     <= 1'b0;
    end
  end

  // --------------------
  // units
  // --------------------

  int_div_iterative div0 (
    .clk         (clk),
    .reset       (reset),
    .is_signed   (req_op == imuldiv_pkg::OP_DIV),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy && !unit_mul)
  );

  int_mul_iterative mul0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (resp_rdy && unit_mul)
  );

  // --------------------
  // response
  // --------------------

  assign resp_val    = unit_mul ? mul_resp_val : div_resp_val;
  assign resp_result = unit_mul ? mul_resp_result : div_resp_result;
  assign resp_go     = resp_val && resp_rdy;

  // owning unit stays out of idle for the whole op, nothing new can be taken
  assert property (@(posedge clk) disable iff (reset)
    busy |-> !(unit_mul ? mul_req_rdy : div_req_rdy));

  // units have returned to idle by the time the top is free
  assert property (@(posedge clk) disable iff (reset)
    !busy |-> (div_req_rdy && mul_req_rdy));

endmodule

// File: hdl/int_mul_iterative.sv
`timescale 1ns/1ps
// --------------------
// iterative signed multiplier
// shift-add on magnitudes, sign applied at the output
// --------------------
module int_mul_iterative (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [imuldiv_pkg::DATA_W-1:0]    req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]    req_b,
  input  logic                              req_val,
  output logic                              req_rdy,
  output logic [imuldiv_pkg::RESULT_W-1:0]  resp_result,
  output logic                              resp_val,
  input  logic                              resp_rdy
);

  imuldiv_pkg::iter_state_e         state;
  logic [imuldiv_pkg::COUNT_W-1:0]  count;
  logic                             req_go;
  logic                             resp_go;
  logic                             steps_done;
  logic                             step;

  // product, shifting multiplicand and shifting multiplier
  logic [imuldiv_pkg::RESULT_W-1:0] prod_reg;
  logic [imuldiv_pkg::RESULT_W-1:0] mcand_reg;
  logic [imuldiv_pkg::DATA_W-1:0]   mplier_reg;
  logic                             neg_reg;
  logic [imuldiv_pkg::DATA_W-1:0]   a_mag;
  logic [imuldiv_pkg::DATA_W-1:0]   b_mag;

  assign req_go     = req_val && req_rdy;
  assign resp_go    = resp_val && resp_rdy;
  assign steps_done = (count == imuldiv_pkg::ITER_COUNT);
  assign step       = (state == imuldiv_pkg::ST_CALC) && !steps_done;

  // --------------------
  // state machine
  // --------------------

  // same cycle count as the divider
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_pkg::ST_IDLE: begin
          if (req_go) begin
            state <= imuldiv_pkg::ST_CALC;
            count <= '0;
          end
        end
        imuldiv_pkg::ST_CALC: begin
          if (steps_done) state <= imuldiv_pkg::ST_DONE;
          else count <= count + 1'b1;
        end
        imuldiv_pkg::ST_DONE: begin
          if (resp_go) state <= imuldiv_pkg::ST_IDLE;
        end
        default: state <= imuldiv_pkg::ST_IDLE;
      endcase
    end
  end

  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state == imuldiv_pkg::ST_DONE);

  // --------------------
  // datapath
  // --------------------

  assign a_mag = req_a[imuldiv_pkg::DATA_W-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[imuldiv_pkg::DATA_W-1] ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      prod_reg   <= '0;
      mcand_reg  <= {{imuldiv_pkg::DATA_W{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      neg_reg    <= req_a[imuldiv_pkg::DATA_W-1] ^ req_b[imuldiv_pkg::DATA_W-1];
    end else if (step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_reg[0]) prod_reg <= prod_reg + mcand_reg;
      mcand_reg  <= {mcand_reg[imuldiv_pkg::RESULT_W-2:0], 1'b0};
      mplier_reg <= {1'b0, mplier_reg[imuldiv_pkg::DATA_W-1:1]};
    end
  end

  // product negative when exactly one operand is
  assign resp_result = neg_reg ? (~prod_reg + 1'b1) : prod_reg;

  // --------------------
  // checks
  // --------------------

  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val));

  assert property (@(posedge clk) disable iff (reset)
    step |-> (count < imuldiv_pkg::ITER_COUNT));

  assert property (@(posedge clk) disable iff (reset)
    (state == imuldiv_pkg::ST_DONE && !resp_rdy) |=> (state == imuldiv_pkg::ST_DONE));

endmodule

// File: int_div/int_div_iterative.sv
`timescale 1ns/1ps
// --------------------
// iterative 32-bit divider
// control and datapath joined
// --------------------
module int_div_iterative (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              is_signed,
  input  logic [imuldiv_pkg::DATA_W-1:0]    req_a,
  input  logic [imuldiv_pkg::DATA_W-1:0]    req_b,
  input  logic                              req_val,
  output logic                              req_rdy,
  output logic [imuldiv_pkg::RESULT_W-1:0]  resp_result,
  output logic                              resp_val,
  input  logic                              resp_rdy
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;

  // --------------------
  // datapath
  // --------------------

  int_div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .is_signed (is_signed),
    .a         (req_a),
    .b         (req_b),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .result    (resp_result)
  );

  // --------------------
  // control
  // --------------------

  // owns both handshakes
  int_div_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel)
  );

endmodule

// File: int_div/int_div_ctrl.sv
`timescale 1ns/1ps
// --------------------
// divider control: idle/calc/done FSM
// with the iteration counter
// --------------------
module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel
);

  imuldiv_pkg::iter_state_e         state;
  imuldiv_pkg::iter_state_e         state_next;
  logic [imuldiv_pkg::COUNT_W-1:0]  count;
  logic                             req_go;
  logic                             resp_go;
  logic                             steps_done;

  assign req_go     = req_val && req_rdy;
  assign resp_go    = resp_val && resp_rdy;
  // all steps taken, one more cycle in calc before done
  assign steps_done = (count == imuldiv_pkg::ITER_COUNT);

  // --------------------
  // state machine
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: if (req_go) state_next = imuldiv_pkg::ST_CALC;
      imuldiv_pkg::ST_CALC: if (steps_done) state_next = imuldiv_pkg::ST_DONE;
      imuldiv_pkg::ST_DONE: if (resp_go) state_next = imuldiv_pkg::ST_IDLE;
      default: state_next = imuldiv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // counts steps taken, restarts on every accepted request
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (req_go) begin
      count <= '0;
    end else if (state == imuldiv_pkg::ST_CALC && !steps_done) begin
      count <= count + 1'b1;
    end
  end

  // --------------------
  // outputs to the datapath
  // --------------------

  assign req_rdy   = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val  = (state == imuldiv_pkg::ST_DONE);
  assign b_en      = req_go;
  assign a_mux_sel = (state == imuldiv_pkg::ST_CALC);
  // load on accept, then one step per calc cycle
  assign a_en      = req_go || (a_mux_sel && !steps_done);

  // --------------------
  // checks
  // --------------------

  // request and response sides never open together
  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val));

  // no step is ever taken past the last iteration
  assert property (@(posedge clk) disable iff (reset)
    (a_en && a_mux_sel) |-> (count < imuldiv_pkg::ITER_COUNT));

  // result held until the consumer takes it
  assert property (@(posedge clk) disable iff (reset)
    (state == imuldiv_pkg::ST_DONE && !resp_rdy) |=> (state == imuldiv_pkg::ST_DONE));

endmodule

// File: int_div/int_div_dpath.sv
`timescale 1ns/1ps
// --------------------
// divider datapath: operand unsigning, restoring
// shift-subtract step and sign fix-up of the result
// --------------------
module int_div_dpath (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              is_signed,
  input  logic [imuldiv_pkg::DATA_W-1:0]    a,
  input  logic [imuldiv_pkg::DATA_W-1:0]    b,
  input  logic                              a_en,
  input  logic                              b_en,
  input  logic                              a_mux_sel,
  output logic [imuldiv_pkg::RESULT_W-1:0]  result
);

  // {remainder, quotient} working register with one guard bit on top
  logic [imuldiv_pkg::RESULT_W:0]   rq_reg;
  logic [imuldiv_pkg::DATA_W-1:0]   b_mag_reg;
  logic                             signed_reg;
  logic                             sign_a_reg;
  logic                             sign_b_reg;

  logic [imuldiv_pkg::DATA_W-1:0]   a_mag;
  logic [imuldiv_pkg::DATA_W-1:0]   b_mag;
  logic [imuldiv_pkg::RESULT_W:0]   rq_init;
  logic [imuldiv_pkg::RESULT_W:0]   rq_shift;
  logic [imuldiv_pkg::RESULT_W:0]   b_aligned;
  logic [imuldiv_pkg::RESULT_W:0]   sub_out;
  logic [imuldiv_pkg::RESULT_W:0]   rq_step;
  logic [imuldiv_pkg::DATA_W-1:0]   quo_mag;
  logic [imuldiv_pkg::DATA_W-1:0]   rem_mag;
  logic                             neg_quo;
  logic                             neg_rem;

  // --------------------
  // operand load
  // --------------------

  // magnitudes, only for signed divide
  assign a_mag = (is_signed && a[imuldiv_pkg::DATA_W-1]) ? (~a + 1'b1) : a;
  assign b_mag = (is_signed && b[imuldiv_pkg::DATA_W-1]) ? (~b + 1'b1) : b;

  // dividend starts in the quotient half
  assign rq_init = {{(imuldiv_pkg::DATA_W+1){1'b0}}, a_mag};

  // --------------------
  // iteration step
  // --------------------

  assign rq_shift  = {rq_reg[imuldiv_pkg::RESULT_W-1:0], 1'b0};
  // divisor lined up with the remainder half
  assign b_aligned = {1'b0, b_mag_reg, {imuldiv_pkg::DATA_W{1'b0}}};
  assign sub_out   = rq_shift - b_aligned;

  // negative difference means restore, else keep it and set quotient bit
  assign rq_step = sub_out[imuldiv_pkg::RESULT_W] ? rq_shift :
                   {sub_out[imuldiv_pkg::RESULT_W:1], 1'b1};

  // sign bits and flag are captured with the divisor
  always_ff @(posedge clk) begin
    if (reset) begin
      signed_reg <= 1'b0;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (b_en) begin
      signed_reg <= is_signed;
      sign_a_reg <= a[imuldiv_pkg::DATA_W-1];
      sign_b_reg <= b[imuldiv_pkg::DATA_W-1];
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      b_mag_reg <= b_mag;
    end
  end

  // low select loads the dividend, high select takes one step
  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_reg <= a_mux_sel ? rq_step : rq_init;
    end
  end

  // --------------------
  // sign fix-up
  // --------------------

  assign quo_mag = rq_reg[imuldiv_pkg::DATA_W-1:0];
  assign rem_mag = rq_reg[imuldiv_pkg::RESULT_W-1:imuldiv_pkg::DATA_W];

  // quotient negative when signs differ, remainder follows the dividend
  assign neg_quo = signed_reg && (sign_a_reg ^ sign_b_reg);
  assign neg_rem = signed_reg && sign_a_reg;

  assign result = {neg_rem ? (~rem_mag + 1'b1) : rem_mag,
                   neg_quo ? (~quo_mag + 1'b1) : quo_mag};

endmodule

// File: common/imuldiv_pkg.sv
// --------------------
// imuldiv shared definitions
// widths, iteration count, opcodes and unit states
// --------------------
package imuldiv_pkg;

  // --------------------
  // widths
  // --------------------

  // operand width of both units
  localparam int DATA_W = 32;

  // full result, remainder on top for divide
  localparam int RESULT_W = 64;

  // iteration counter has to reach ITER_COUNT itself
  localparam int COUNT_W = 6;

  // one shift step per operand bit
  localparam logic [COUNT_W-1:0] ITER_COUNT = 6'd32;

  // --------------------
  // encodings
  // --------------------

  // request opcodes
  // any other code falls through to the divider as unsigned
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } muldiv_op_e;

  // states shared by the iterative units
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_e;

endpackage
